// ==== vdpPkg.sv ====
// vdp package
// shared widths, command codes, register indices and the command byte layout
`default_nettype none

package vdpPkg;

    localparam int vramAddrW = 14;
    localparam int cramAddrW = 5;
    localparam int numRegs   = 11;

    typedef logic [vramAddrW-1:0] vramAddr_t;
    typedef logic [7:0]           byte_t;

    // top two bits of the second control byte
    typedef enum logic [1:0] {
        cmdVramRead  = 2'b00,
        cmdVramWrite = 2'b01,
        cmdRegWrite  = 2'b10,
        cmdCramWrite = 2'b11
    } cmdCode_t;

    // second control byte, read as a register select or as the high address bits
    typedef union packed {
        struct packed {
            cmdCode_t   code;
            logic [1:0] pad;  // ignored by the VDP
            logic [3:0] idx;  // register number
        } asReg;
        struct packed {
            cmdCode_t   code;
            logic [5:0] hi;   // address bits 13..8
        } asAddr;
    } cmdByte_u;

    // control register numbers
    localparam logic [3:0] regMode0      = 4'd0;
    localparam logic [3:0] regMode1      = 4'd1;
    localparam logic [3:0] regNameBase   = 4'd2;
    localparam logic [3:0] regSatBase    = 4'd5;
    localparam logic [3:0] regSprPatBase = 4'd6;
    localparam logic [3:0] regBackdrop   = 4'd7;
    localparam logic [3:0] regHScroll    = 4'd8;
    localparam logic [3:0] regVScroll    = 4'd9;
    localparam logic [3:0] regLineCount  = 4'd10;

    // status byte layout
    localparam int statVblBit      = 7;
    localparam int statOverflowBit = 6;
    localparam int statCollideBit  = 5;

endpackage

`default_nettype wire

// ==== portCmdIf.sv ====
// port command interface
// decoded write, load and step commands from the port FSM to the data blocks
`default_nettype none

interface portCmdIf;
    import vdpPkg::*;

    logic     loadLo;   // low address byte from latched
    logic     loadHi;   // high bits from cmd
    logic     step;     // address increment
    logic     vramWe;
    logic     cramWe;
    logic     regWe;
    logic     fetch;    // refill read-ahead buffer
    cmdByte_u cmd;      // second control byte
    byte_t    latched;  // first byte or data byte

    modport fsm (
        output loadLo, loadHi, step, vramWe, cramWe, regWe, fetch, cmd, latched
    );

    modport counter (input loadLo, loadHi, step, cmd, latched);

    modport regs (input regWe, cmd, latched);

    modport mem (input vramWe, cramWe, fetch, latched);

endinterface

`default_nettype wire

// ==== ctrlPortFsm.sv ====
// control port FSM
// pairs control bytes, decodes commands and turns data-port strobes into pulses
`default_nettype none

module ctrlPortFsm (
    input  logic          cpuClk,
    input  logic          rst_l,
    input  logic          csw_l,
    input  logic          csr_l,
    input  logic          mode,
    input  vdpPkg::byte_t dataIn,
    portCmdIf.fsm         cmdIf,
    output logic          statusRead
);
    import vdpPkg::*;

    logic       pairSecond;    // waiting for the second byte
    cmdCode_t   accessCode;    // code of the last command
    cmdByte_u   cmdIn;
    logic       ctrlWrite;
    logic       dataWrite;
    logic       dataRead;
    logic       prefetchPend;  // fetch due after an address load

    assign cmdIn      = dataIn;
    assign ctrlWrite  = ~csw_l & mode;
    assign dataWrite  = ~csw_l & ~mode;
    assign dataRead   = ~csr_l & ~mode;
    assign statusRead = ~csr_l & mode;

    always_ff @(posedge cpuClk, negedge rst_l) begin
        if (!rst_l) begin
            pairSecond    <= 1'b0;
            accessCode    <= cmdVramRead;
            prefetchPend  <= 1'b0;
            cmdIf.loadLo  <= 1'b0;
            cmdIf.loadHi  <= 1'b0;
            cmdIf.step    <= 1'b0;
            cmdIf.vramWe  <= 1'b0;
            cmdIf.cramWe  <= 1'b0;
            cmdIf.regWe   <= 1'b0;
            cmdIf.fetch   <= 1'b0;
        end else begin
            cmdIf.loadLo <= 1'b0;
            cmdIf.loadHi <= 1'b0;
            cmdIf.vramWe <= 1'b0;
            cmdIf.cramWe <= 1'b0;
            cmdIf.regWe  <= 1'b0;
            // a pending prefetch reads the freshly loaded address and then steps
            cmdIf.fetch  <= prefetchPend;
            cmdIf.step   <= prefetchPend;
            prefetchPend <= 1'b0;

            if (ctrlWrite) begin
                if (!pairSecond) begin
                    cmdIf.loadLo <= 1'b1;
                    pairSecond   <= 1'b1;
                end else begin
                    accessCode <= cmdIn.asAddr.code;
                    pairSecond <= 1'b0;
                    if (cmdIn.asReg.code == cmdRegWrite) begin
                        cmdIf.regWe <= 1'b1;
                    end else begin
                        cmdIf.loadHi <= 1'b1;
                        prefetchPend <= (cmdIn.asAddr.code == cmdVramRead);
                    end
                end
            end else if (dataWrite) begin
                cmdIf.cramWe <= (accessCode == cmdCramWrite);
                cmdIf.vramWe <= (accessCode != cmdCramWrite);  // reads fall back to VRAM
                cmdIf.step   <= 1'b1;
                pairSecond   <= 1'b0;
            end else if (dataRead) begin
                cmdIf.fetch <= 1'b1;  // refill from the address one past the buffer
                cmdIf.step  <= 1'b1;
                pairSecond  <= 1'b0;
            end else if (statusRead) begin
                pairSecond <= 1'b0;
            end
        end
    end

    // payload bytes
    always_ff @(posedge cpuClk) begin
        if ((ctrlWrite && !pairSecond) || dataWrite) begin
            cmdIf.latched <= dataIn;
        end
        if (ctrlWrite && pairSecond) begin
            cmdIf.cmd <= cmdIn;
        end
    end

endmodule

`default_nettype wire

// ==== vramAddrCounter.sv ====
// VRAM address counter
// 14-bit address loaded in two parts, stepped after each data access
`default_nettype none

module vramAddrCounter (
    input  logic              cpuClk,
    input  logic              rst_l,
    portCmdIf.counter         cmdIf,
    output vdpPkg::vramAddr_t addr
);

    always_ff @(posedge cpuClk, negedge rst_l) begin
        if (!rst_l) begin
            addr <= '0;
        end else if (cmdIf.loadLo) begin
            addr[7:0] <= cmdIf.latched;
        end else if (cmdIf.loadHi) begin
            addr[13:8] <= cmdIf.cmd.asAddr.hi;  // completes the address
        end else if (cmdIf.step) begin
            addr <= addr + 1'b1;  // wraps at 16K
        end
    end

endmodule

`default_nettype wire

// ==== vdpRegFile.sv ====
// VDP control registers
// select decoder, eleven write-only registers and their decoded fields
`default_nettype none

module vdpRegFile (
    input  logic              cpuClk,
    input  logic              rst_l,
    portCmdIf.regs            cmdIf,
    output vdpPkg::vramAddr_t nameBaseAddr,
    output vdpPkg::vramAddr_t satBaseAddr,
    output vdpPkg::vramAddr_t sprPatBaseAddr,
    output vdpPkg::byte_t     hScroll,
    output vdpPkg::byte_t     vScroll,
    output vdpPkg::byte_t     lineCount,
    output logic              displayBlank,
    output logic              scrollInhibitH,
    output logic              scrollInhibitV,
    output logic [3:0]        backdropIdx,
    output logic              frameIntEn,
    output logic              lineIntEn
);
    import vdpPkg::*;

    byte_t              ctrlReg [numRegs];
    logic [numRegs-1:0] regEn;

    always_comb begin
        regEn = '0;
        if (cmdIf.regWe && (cmdIf.cmd.asReg.idx < numRegs)) begin  // 11..15 dropped
            regEn[cmdIf.cmd.asReg.idx] = 1'b1;
        end
    end

    always_ff @(posedge cpuClk, negedge rst_l) begin
        if (!rst_l) begin
            for (int i = 0; i < numRegs; i++) begin
                ctrlReg[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (regEn[i]) begin
                    ctrlReg[i] <= cmdIf.latched;  // data came as the first byte
                end
            end
        end
    end

    assign nameBaseAddr   = {ctrlReg[regNameBase][3:1], 11'b0};  // 2K steps
    assign satBaseAddr    = {ctrlReg[regSatBase][6:1], 8'b0};
    assign sprPatBaseAddr = {ctrlReg[regSprPatBase][2], 13'b0};  // 0 or 8K
    assign hScroll        = ctrlReg[regHScroll];
    assign vScroll        = ctrlReg[regVScroll];
    assign lineCount      = ctrlReg[regLineCount];
    assign backdropIdx    = ctrlReg[regBackdrop][3:0];

    assign scrollInhibitV = ctrlReg[regMode0][7];
    assign scrollInhibitH = ctrlReg[regMode0][6];
    assign lineIntEn      = ctrlReg[regMode0][4];
    assign displayBlank   = ~ctrlReg[regMode1][6];  // bit 6 set turns the display on
    assign frameIntEn     = ctrlReg[regMode1][5];

endmodule

`default_nettype wire

// ==== videoMem.sv ====
// video memories
// 16K VRAM with read-ahead buffer and 32-entry CRAM with a backdrop read port
`default_nettype none

module videoMem (
    input  logic              cpuClk,
    portCmdIf.mem             cmdIf,
    input  vdpPkg::vramAddr_t addr,
    input  logic [3:0]        backdropIdx,
    output vdpPkg::byte_t     readBuf,
    output vdpPkg::byte_t     backdropColor
);
    import vdpPkg::*;

    byte_t vram [2**vramAddrW];
    byte_t cram [2**cramAddrW];

    always_ff @(posedge cpuClk) begin
        if (cmdIf.vramWe) begin
            vram[addr] <= cmdIf.latched;
        end
        if (cmdIf.fetch) begin
            readBuf <= vram[addr];  // read ahead for the next data read
        end
    end

    // CRAM uses only the low address bits
    always_ff @(posedge cpuClk) begin
        if (cmdIf.cramWe) begin
            cram[addr[cramAddrW-1:0]] <= cmdIf.latched;
        end
    end

    always_ff @(posedge cpuClk) begin
        backdropColor <= cram[{1'b1, backdropIdx}];  // sprite half of the palette
    end

endmodule

`default_nettype wire

// ==== statusInt.sv ====
// status and interrupt block
// latches frame, line and sprite events, builds the status byte and int_l
`default_nettype none

module statusInt (
    input  logic          cpuClk,
    input  logic          rst_l,
    input  logic          statusRead,
    input  logic          vBlankPulse,
    input  logic          lineIntPulse,
    input  logic          sprOverflowPulse,
    input  logic          sprCollidePulse,
    input  logic          frameIntEn,
    input  logic          lineIntEn,
    output vdpPkg::byte_t status,
    output logic          int_l
);
    import vdpPkg::*;

    // bit order: line, collide, overflow, vbl
    logic [3:0] setPulse;
    logic [3:0] flags;

    assign setPulse = {lineIntPulse, sprCollidePulse, sprOverflowPulse, vBlankPulse};

    always_ff @(posedge cpuClk, negedge rst_l) begin
        if (!rst_l) begin
            flags <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (setPulse[i]) begin
                    flags[i] <= 1'b1;  // new event beats the clear
                end else if (statusRead) begin
                    flags[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        status                  = '0;
        status[statVblBit]      = flags[0];
        status[statOverflowBit] = flags[1];
        status[statCollideBit]  = flags[2];
    end

    assign int_l = ~((frameIntEn & flags[0]) | (lineIntEn & flags[3]));

endmodule

`default_nettype wire

// ==== vdpCpuPort.sv ====
// VDP CPU port
// control and data port of the video processor, memories, registers and status
`default_nettype none

module vdpCpuPort (
    input  logic              cpuClk,
    input  logic              rst_l,
    input  logic              csw_l,
    input  logic              csr_l,
    input  logic              mode,              // 1 control, 0 data
    input  vdpPkg::byte_t     dataIn,
    input  logic              vBlankPulse,
    input  logic              lineIntPulse,
    input  logic              sprOverflowPulse,
    input  logic              sprCollidePulse,
    output vdpPkg::byte_t     dataOut,
    output logic              int_l,
    output vdpPkg::vramAddr_t nameBaseAddr,
    output vdpPkg::vramAddr_t satBaseAddr,
    output vdpPkg::vramAddr_t sprPatBaseAddr,
    output vdpPkg::byte_t     hScroll,
    output vdpPkg::byte_t     vScroll,
    output vdpPkg::byte_t     lineCount,
    output vdpPkg::byte_t     backdropColor,
    output logic              displayBlank,
    output logic              scrollInhibitH,
    output logic              scrollInhibitV
);
    import vdpPkg::*;

    vramAddr_t  addr;
    byte_t      readBuf;
    byte_t      status;
    logic       statusRead;
    logic [3:0] backdropIdx;
    logic       frameIntEn;
    logic       lineIntEn;

    portCmdIf cmdIf ();

    ctrlPortFsm uFsm (
        .cpuClk    (cpuClk),
        .rst_l     (rst_l),
        .csw_l     (csw_l),
        .csr_l     (csr_l),
        .mode      (mode),
        .dataIn    (dataIn),
        .cmdIf     (cmdIf.fsm),
        .statusRead(statusRead)
    );

    vramAddrCounter uAddr (
        .cpuClk(cpuClk),
        .rst_l (rst_l),
        .cmdIf (cmdIf.counter),
        .addr  (addr)
    );

    vdpRegFile uRegs (
        .cpuClk        (cpuClk),
        .rst_l         (rst_l),
        .cmdIf         (cmdIf.regs),
        .nameBaseAddr  (nameBaseAddr),
        .satBaseAddr   (satBaseAddr),
        .sprPatBaseAddr(sprPatBaseAddr),
        .hScroll       (hScroll),
        .vScroll       (vScroll),
        .lineCount     (lineCount),
        .displayBlank  (displayBlank),
        .scrollInhibitH(scrollInhibitH),
        .scrollInhibitV(scrollInhibitV),
        .backdropIdx   (backdropIdx),
        .frameIntEn    (frameIntEn),
        .lineIntEn     (lineIntEn)
    );

    videoMem uMem (
        .cpuClk       (cpuClk),
        .cmdIf        (cmdIf.mem),
        .addr         (addr),
        .backdropIdx  (backdropIdx),
        .readBuf      (readBuf),
        .backdropColor(backdropColor)
    );

    statusInt uStatus (
        .cpuClk          (cpuClk),
        .rst_l           (rst_l),
        .statusRead      (statusRead),
        .vBlankPulse     (vBlankPulse),
        .lineIntPulse    (lineIntPulse),
        .sprOverflowPulse(sprOverflowPulse),
        .sprCollidePulse (sprCollidePulse),
        .frameIntEn      (frameIntEn),
        .lineIntEn       (lineIntEn),
        .status          (status),
        .int_l           (int_l)
    );

    // read data register, held until the next read strobe
    always_ff @(posedge cpuClk, negedge rst_l) begin
        if (!rst_l) begin
            dataOut <= '0;
        end else if (!csr_l) begin
            dataOut <= mode ? status : readBuf;
        end
    end

endmodule

`default_nettype wire

// ==== vdpTb.sv ====
// VDP CPU port testbench
// runs the operations in vdpCases.txt against the port and checks every result
`default_nettype none

module vdpTb;
    timeunit 1ns;
    timeprecision 1ps;
    import vdpPkg::*;

    logic      cpuClk;
    logic      rst_l;
    logic      csw_l;
    logic      csr_l;
    logic      mode;
    byte_t     dataIn;
    logic      vBlankPulse;
    logic      lineIntPulse;
    logic      sprOverflowPulse;
    logic      sprCollidePulse;
    byte_t     dataOut;
    logic      int_l;
    vramAddr_t nameBaseAddr;
    vramAddr_t satBaseAddr;
    vramAddr_t sprPatBaseAddr;
    byte_t     hScroll;
    byte_t     vScroll;
    byte_t     lineCount;
    byte_t     backdropColor;
    logic      displayBlank;
    logic      scrollInhibitH;
    logic      scrollInhibitV;

    int seed       = 32'h24984b97;
    int cycleCount = 0;
    int cycleLimit = 50;  // grows as case lines are read

    vdpCpuPort dut_i (.*);

    initial begin
        cpuClk = 1'b0;
        forever #50 cpuClk = ~cpuClk;
    end

    task automatic endInFailure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    always @(posedge cpuClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("ERROR: the run hung, %0d cycles passed without finishing", cycleCount);
            endInFailure();
        end
    end

    task automatic checkByte(input string name, input byte_t expVal, input byte_t actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s: expected %h, actual %h", name, expVal, actVal);
            endInFailure();
        end
    endtask

    task automatic checkAddr(input string name, input vramAddr_t expVal,
                             input vramAddr_t actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s: expected %h, actual %h", name, expVal, actVal);
            endInFailure();
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("FAIL %s: expected %b, actual %b", name, expVal, actVal);
            endInFailure();
        end
    endtask

    // one strobe cycle, then three idle cycles
    task automatic doAccess(input logic isWrite, input logic isCtl, input byte_t data);
        @(posedge cpuClk);
        mode   <= isCtl;
        dataIn <= data;
        if (isWrite) begin
            csw_l <= 1'b0;
        end else begin
            csr_l <= 1'b0;
        end
        @(posedge cpuClk);
        csw_l <= 1'b1;
        csr_l <= 1'b1;
        repeat (3) @(posedge cpuClk);
    endtask

    task automatic pulseInput(input string which);
        @(posedge cpuClk);
        case (which)
            "vbl":   vBlankPulse      <= 1'b1;
            "line":  lineIntPulse     <= 1'b1;
            "ovf":   sprOverflowPulse <= 1'b1;
            "col":   sprCollidePulse  <= 1'b1;
            default: begin
                $display("ERROR: unknown pulse input %s in the cases file", which);
                endInFailure();
            end
        endcase
        @(posedge cpuClk);
        vBlankPulse      <= 1'b0;
        lineIntPulse     <= 1'b0;
        sprOverflowPulse <= 1'b0;
        sprCollidePulse  <= 1'b0;
        repeat (3) @(posedge cpuClk);
    endtask

    // random bytes written from start, then read back through the read-ahead buffer
    task automatic runBurst(input vramAddr_t start, input int count, input string tag);
        byte_t written [$];
        int    rnd;
        doAccess(1'b1, 1'b1, start[7:0]);
        doAccess(1'b1, 1'b1, {2'b01, start[13:8]});  // write code
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            written.push_back(rnd[7:0]);
            doAccess(1'b1, 1'b0, rnd[7:0]);
        end
        doAccess(1'b1, 1'b1, start[7:0]);
        doAccess(1'b1, 1'b1, {2'b00, start[13:8]});  // read code, prefetch
        for (int i = 0; i < count; i++) begin
            doAccess(1'b0, 1'b0, 8'h00);
            @(negedge cpuClk);
            checkByte($sformatf("%s[%0d]", tag, i), written[i], dataOut);
        end
    endtask

    task automatic checkOutput(input string port, input logic [15:0] expVal,
                               input string tag);
        case (port)
            "dataOut":    checkByte(tag, expVal[7:0], dataOut);
            "nameBase":   checkAddr(tag, expVal[13:0], nameBaseAddr);
            "satBase":    checkAddr(tag, expVal[13:0], satBaseAddr);
            "sprPatBase": checkAddr(tag, expVal[13:0], sprPatBaseAddr);
            "hScroll":    checkByte(tag, expVal[7:0], hScroll);
            "vScroll":    checkByte(tag, expVal[7:0], vScroll);
            "lineCount":  checkByte(tag, expVal[7:0], lineCount);
            "backdrop":   checkByte(tag, expVal[7:0], backdropColor);
            "blank":      checkBit(tag, expVal[0], displayBlank);
            "inhibitH":   checkBit(tag, expVal[0], scrollInhibitH);
            "inhibitV":   checkBit(tag, expVal[0], scrollInhibitV);
            default: begin
                $display("ERROR: unknown output %s in the cases file", port);
                endInFailure();
            end
        endcase
    endtask

    task automatic runCase(input string op, input string port, input logic [15:0] value,
                           input logic [15:0] expVal, input string tag);
        logic isCtl;
        isCtl = (port == "ctl") || (port == "sts");
        case (op)
            "W": doAccess(1'b1, isCtl, value[7:0]);
            "R": begin
                doAccess(1'b0, isCtl, 8'h00);
                @(negedge cpuClk);  // dataOut holds until the next read
                checkByte(tag, expVal[7:0], dataOut);
            end
            "P": pulseInput(port);
            "I": begin
                @(negedge cpuClk);
                checkBit(tag, expVal[0], int_l);
            end
            "C": begin
                @(negedge cpuClk);
                checkOutput(port, expVal, tag);
            end
            "B": runBurst(value[13:0], int'(expVal), tag);
            default: begin
                $display("ERROR: unknown operation %s in the cases file", op);
                endInFailure();
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          lineNo;
        int          n;
        string       line;
        string       op;
        string       port;
        string       tag;
        logic [15:0] value;
        logic [15:0] expVal;
        rst_l            = 1'b0;
        csw_l            = 1'b1;
        csr_l            = 1'b1;
        mode             = 1'b0;
        dataIn           = '0;
        vBlankPulse      = 1'b0;
        lineIntPulse     = 1'b0;
        sprOverflowPulse = 1'b0;
        sprCollidePulse  = 1'b0;
        lineNo           = 0;
        repeat (8) @(posedge cpuClk);
        rst_l <= 1'b1;

        fd = $fopen("vdpCases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the cases file vdpCases.txt could not be opened");
            endInFailure();
        end
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments and blanks
                n = $sscanf(line, "%s %s %h %h %s", op, port, value, expVal, tag);
                if (n != 5) begin
                    $display("ERROR: line %0d of the cases file is malformed", lineNo);
                    endInFailure();
                end
                cycleLimit += 8;
                if (op == "B") begin
                    cycleLimit += 10 * int'(expVal) + 28;  // five cycles per access
                end
                runCase(op, port, value, expVal, tag);
            end
        end
        $fclose(fd);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vdpCases.txt ====
# op port value expected tag, value and expected in hex
# op: W write, R read and check, P pulse, I check int_l, C check output, B random VRAM burst
C dataOut 0 00 resetData
I int_l 0 1 resetInt
W ctl 0E 0 nameLo
W ctl 82 0 nameHi
C nameBase 0 3800 nameBase
W ctl FF 0 satLo
W ctl 85 0 satHi
C satBase 0 3F00 satBase
W ctl 04 0 sprPatLo
W ctl 86 0 sprPatHi
C sprPatBase 0 2000 sprPatBase
W ctl 5A 0 hScrollLo
W ctl 88 0 hScrollHi
C hScroll 0 5A hScroll
W ctl A5 0 vScrollLo
W ctl 89 0 vScrollHi
C vScroll 0 A5 vScroll
W ctl 33 0 lineCntLo
W ctl 8A 0 lineCntHi
C lineCount 0 33 lineCount
W ctl C0 0 mode0Lo
W ctl 80 0 mode0Hi
C inhibitH 0 1 inhibitH
C inhibitV 0 1 inhibitV
C blank 0 1 displayOff
W ctl 40 0 mode1Lo
W ctl 81 0 mode1Hi
C blank 0 0 displayOn
W ctl 00 0 bigIdxLo
W ctl 8D 0 bigIdxHi
C nameBase 0 3800 bigIdxName
C hScroll 0 5A bigIdxScroll
C lineCount 0 33 bigIdxLine
B vram 0100 10 burst
W ctl 03 0 backdropLo
W ctl 87 0 backdropHi
W ctl 13 0 cramLo
W ctl C0 0 cramHi
W dat 2A 0 cramData
C backdrop 0 2A backdrop
P vbl 0 0 vblPulse
P ovf 0 0 ovfPulse
P col 0 0 colPulse
R sts 0 E0 statusAll
R sts 0 00 statusClear
P vbl 0 0 vblNoEnable
I int_l 0 1 frameNoEnable
P line 0 0 lineNoEnable
I int_l 0 1 lineNoEnable
R sts 0 80 statusVbl
W ctl 60 0 frameEnLo
W ctl 81 0 frameEnHi
I int_l 0 1 frameEnIdle
P vbl 0 0 vblFrame
I int_l 0 0 frameInt
R sts 0 80 frameAck
I int_l 0 1 frameCleared
W ctl D0 0 lineEnLo
W ctl 80 0 lineEnHi
P line 0 0 linePulse
I int_l 0 0 lineInt
R sts 0 00 lineAck
I int_l 0 1 lineCleared
W ctl 12 0 pairFirst
R sts 0 00 pairStatus
W ctl 0C 0 pairLo
W ctl 82 0 pairHi
C nameBase 0 3000 pairName

// ==== flist.f ====
vdpPkg.sv
portCmdIf.sv
ctrlPortFsm.sv
vramAddrCounter.sv
vdpRegFile.sv
videoMem.sv
statusInt.sv
vdpCpuPort.sv
vdpTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the VDP CPU port testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f flist.f --top-module vdpTb -o vdpSim
./obj_dir/vdpSim
